/* verilog/cm_pkg.sv */
// Shared widths, types, cup volumes and drink recipes of the coffee maker
// Referenced by scoped names from every RTL file and the testbench
package cm_pkg;
	// ####################
	// Widths
	localparam int NUM_TANKS = 4;
	localparam int LEVEL_W = 10;
	localparam int RATIO_W = 3;
	localparam int RSUM_W = 5;
	// Product of portion and ratio, plus one sign bit for the remainder
	localparam int DRAW_W = LEVEL_W + RATIO_W;
	localparam int REM_W = DRAW_W + 1;
	// Divider bit index
	localparam int CNT_W = $clog2(LEVEL_W);

	typedef logic [LEVEL_W-1:0] level_t;
	typedef logic [RATIO_W-1:0] ratio_t;

	// Tank k is the k-th value after none
	typedef enum logic [2:0] {none, espresso, milk, chocolate, froth} ingredient_t;
	typedef enum logic [2:0] {no_coffee, latte, cappuccino, mocha} flavor_t;
	typedef enum logic [2:0] {no_size, s, m, l, xl} size_t;
	typedef enum logic {red, green} led_t;

	// ####################
	// Cup volumes
	localparam level_t CUP_S = 10'd240;
	localparam level_t CUP_M = 10'd360;
	localparam level_t CUP_L = 10'd480;
	localparam level_t CUP_XL = 10'd600;

	// Recipes in tank order: espresso, milk, chocolate, froth
	localparam ratio_t LATTE_RATIO [NUM_TANKS] = '{3'd2, 3'd1, 3'd0, 3'd2};
	localparam ratio_t CAPPU_RATIO [NUM_TANKS] = '{3'd2, 3'd1, 3'd0, 3'd1};
	localparam ratio_t MOCHA_RATIO [NUM_TANKS] = '{3'd1, 3'd1, 3'd1, 3'd0};

	function automatic level_t cup_volume(size_t sz);
		case (sz)
			s: return CUP_S;
			m: return CUP_M;
			l: return CUP_L;
			xl: return CUP_XL;
			default: return '0;
		endcase
	endfunction

	function automatic ratio_t recipe_ratio(flavor_t f, int k);
		case (f)
			latte: return LATTE_RATIO[k];
			cappuccino: return CAPPU_RATIO[k];
			mocha: return MOCHA_RATIO[k];
			default: return '0;
		endcase
	endfunction

	// Sum of all ratios, the divisor of the cup volume
	function automatic logic [RSUM_W-1:0] ratio_sum(flavor_t f);
		logic [RSUM_W-1:0] sum;
		sum = '0;
		for (int k = 0; k < NUM_TANKS; k++)
			sum = sum + {{(RSUM_W-RATIO_W){1'b0}}, recipe_ratio(f, k)};
		return sum;
	endfunction
endpackage

/* verilog/tank_if.sv */
`timescale 1ns/1ns
// Command bundle from the order controller to one ingredient tank
// One instance per tank, ctrl side drives, tank side listens
interface tank_if;
	// Refill path
	logic supply_en;
	cm_pkg::level_t supply_amt;
	// End of a refill burst, one cycle
	logic supply_done;
	// Draw evaluation and commit, one cycle
	logic brew_check;
	// Recipe share for this tank
	cm_pkg::ratio_t ratio;
	// Cup volume over ratio sum
	cm_pkg::level_t portion;

	modport ctrl (
		output supply_en, supply_amt, supply_done,
		output brew_check, ratio, portion
	);

	modport tank (
		input supply_en, supply_amt, supply_done,
		input brew_check, ratio, portion
	);
endinterface

/* verilog/order_ctrl.sv */
`timescale 1ns/1ns
// Machine FSM, order capture, recipe lookup and per-tank commands
// Starts the cup divider and strobes the tanks and the judge
module order_ctrl (
	input logic clk,
	input logic rst_n,
	input cm_pkg::ingredient_t select_i,
	input cm_pkg::level_t supply,
	input cm_pkg::flavor_t flavor_btn,
	input cm_pkg::size_t required_size,
	tank_if.ctrl tanks [cm_pkg::NUM_TANKS],
	output logic div_start,
	output cm_pkg::level_t div_dividend,
	output logic [cm_pkg::RSUM_W-1:0] div_divisor,
	input cm_pkg::level_t div_quotient,
	input logic div_done,
	output logic brew_check,
	output logic supply_done,
	output cm_pkg::flavor_t flavor
);
	typedef enum logic [1:0] {st_ready, st_supply, st_divide, st_check} state_t;

	state_t state;
	state_t state_nxt;
	cm_pkg::size_t size_q;
	cm_pkg::level_t portion_q;
	logic refill_req;
	logic order_req;
	logic accept;

	// ####################
	// Request decode
	assign refill_req = (select_i != cm_pkg::none);
	assign order_req = (flavor_btn == cm_pkg::latte) || (flavor_btn == cm_pkg::cappuccino)
		|| (flavor_btn == cm_pkg::mocha);
	// Inputs only matter while idle or refilling
	assign accept = (state == st_ready) || (state == st_supply);
	// Refill wins over an order
	assign div_start = (state == st_ready) && !refill_req && order_req;
	assign brew_check = (state == st_check);

	always_comb
	begin
		state_nxt = state;
		case (state)
			st_ready:
			begin
				if (refill_req)
					state_nxt = st_supply;
				else if (order_req)
					state_nxt = st_divide;
			end
			st_supply:
			begin
				if (!refill_req)
					state_nxt = st_ready;
			end
			st_divide:
			begin
				if (div_done)
					state_nxt = st_check;
			end
			default:
				state_nxt = st_ready;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= st_ready;
			flavor <= cm_pkg::no_coffee;
			size_q <= cm_pkg::no_size;
			supply_done <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			// First idle select ends the burst
			supply_done <= (state == st_supply) && !refill_req;
			if (div_start)
			begin
				flavor <= flavor_btn;
				size_q <= required_size;
			end
		end
	end

	// Portion held for the commit cycle
	always_ff @(posedge clk)
	begin
		if (state == st_divide && div_done)
			portion_q <= div_quotient;
	end

	// ####################
	// Divider operands
	// Dividend bits are only read while dividing, from the latched cup size
	assign div_dividend = cm_pkg::cup_volume(size_q);
	// Divisor from the live buttons on the start edge
	assign div_divisor = (state == st_ready) ? cm_pkg::ratio_sum(flavor_btn)
		: cm_pkg::ratio_sum(flavor);

	// ####################
	// Tank commands
	for (genvar k = 0; k < cm_pkg::NUM_TANKS; k++)
	begin : g_cmd
		assign tanks[k].supply_en = accept && (select_i == cm_pkg::ingredient_t'(k + 1));
		assign tanks[k].supply_amt = supply;
		assign tanks[k].supply_done = supply_done;
		assign tanks[k].brew_check = brew_check;
		assign tanks[k].ratio = cm_pkg::recipe_ratio(flavor, k);
		assign tanks[k].portion = portion_q;
	end

	// A divide result only lands while an order waits for it
	a_done_in_divide: assert property (@(posedge clk) disable iff (!rst_n)
		div_done |-> (state == st_divide));
endmodule

/* verilog/cup_divider.sv */
`timescale 1ns/1ns
// Restoring divider with one quotient bit per cycle from the MSB down
// Operands are read live and must stay stable until done
module cup_divider (
	input logic clk,
	input logic rst_n,
	input logic start,
	input cm_pkg::level_t dividend,
	input logic [cm_pkg::RSUM_W-1:0] divisor,
	output cm_pkg::level_t quotient,
	output logic done
);
	logic busy;
	logic [cm_pkg::CNT_W-1:0] bit_idx;
	logic [cm_pkg::RSUM_W-1:0] rem;
	logic [cm_pkg::RSUM_W+1:0] trial;
	logic q_bit;

	// Shift in the next dividend bit and try the subtraction
	assign trial = {1'b0, rem, dividend[bit_idx]} - {2'b00, divisor};
	assign q_bit = !trial[cm_pkg::RSUM_W+1];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			bit_idx <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				busy <= 1'b1;
				bit_idx <= cm_pkg::CNT_W'(cm_pkg::LEVEL_W - 1);
			end
			else if (busy)
			begin
				bit_idx <= bit_idx - 1'b1;
				// Last bit done
				if (bit_idx == '0)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// Partial remainder and quotient
	always_ff @(posedge clk)
	begin
		if (start)
			rem <= '0;
		else if (busy)
		begin
			rem <= q_bit ? trial[cm_pkg::RSUM_W-1:0] : {rem[cm_pkg::RSUM_W-2:0], dividend[bit_idx]};
			quotient <= {quotient[cm_pkg::LEVEL_W-2:0], q_bit};
		end
	end

	a_divisor_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> (divisor != '0) && !busy);
endmodule

/* verilog/ingredient_tank.sv */
`timescale 1ns/1ns
// One ingredient tank with its fill level, refill, shortage check, draw and LED
// Commands arrive on tank_if and the go/no-go comes from the brew judge
module ingredient_tank (
	input logic clk,
	input logic rst_n,
	tank_if.tank cmd,
	input logic brew_ok,
	output logic short,
	output cm_pkg::level_t level,
	output cm_pkg::led_t led
);
	logic [cm_pkg::DRAW_W-1:0] draw;
	logic signed [cm_pkg::REM_W-1:0] remainder;

	// Amount this recipe takes from the tank
	assign draw = {{cm_pkg::RATIO_W{1'b0}}, cmd.portion} * {{cm_pkg::LEVEL_W{1'b0}}, cmd.ratio};
	// Level after the draw goes negative when short
	assign remainder = {{(cm_pkg::REM_W - cm_pkg::LEVEL_W){1'b0}}, level} - {1'b0, draw};
	assign short = (remainder < 0);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			level <= '0;
			led <= cm_pkg::red;
		end
		else
		begin
			// Refill wraps modulo 1024
			if (cmd.supply_en)
				level <= level + cmd.supply_amt;
			else if (cmd.brew_check && brew_ok)
				level <= remainder[cm_pkg::LEVEL_W-1:0];

			// ####################
			// LED
			if (cmd.brew_check)
			begin
				if (brew_ok)
					led <= (remainder == 0) ? cm_pkg::red : cm_pkg::green;
				else
					led <= (short || level == '0) ? cm_pkg::red : cm_pkg::green;
			end
			else if (cmd.supply_done)
				led <= (level == '0) ? cm_pkg::red : cm_pkg::green;
		end
	end

	// Refill and commit never overlap
	a_no_supply_on_check: assert property (@(posedge clk) disable iff (!rst_n)
		!(cmd.supply_en && cmd.brew_check));
endmodule

/* verilog/brew_judge.sv */
`timescale 1ns/1ns
// Go/no-go over all tanks and the registered result strobe
// Reports the flavor on a good brew and no_coffee otherwise
module brew_judge (
	input logic clk,
	input logic rst_n,
	input logic [cm_pkg::NUM_TANKS-1:0] short,
	input logic brew_check,
	input logic supply_done,
	input cm_pkg::flavor_t flavor,
	output logic brew_ok,
	output logic out_valid,
	output cm_pkg::flavor_t flavor_out
);
	// All shares available
	assign brew_ok = ~|short;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			flavor_out <= cm_pkg::no_coffee;
		end
		else
		begin
			// One result per refill burst or order
			out_valid <= brew_check || supply_done;
			flavor_out <= (brew_check && brew_ok) ? flavor : cm_pkg::no_coffee;
		end
	end

	a_valid_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |=> !out_valid);
endmodule

/* verilog/coffee_maker.sv */
`timescale 1ns/1ns
// Coffee maker top level with plain ports
// Controller, divider, four tanks and the brew judge
module coffee_maker (
	input logic clk,
	input logic rst_n,
	input cm_pkg::ingredient_t select_i,
	input cm_pkg::level_t supply,
	input cm_pkg::flavor_t flavor_btn,
	input cm_pkg::size_t required_size,
	output logic out_valid,
	output cm_pkg::flavor_t flavor_out,
	output cm_pkg::level_t level [cm_pkg::NUM_TANKS],
	output cm_pkg::led_t led [cm_pkg::NUM_TANKS]
);
	// Divider link
	logic div_start;
	cm_pkg::level_t div_dividend;
	logic [cm_pkg::RSUM_W-1:0] div_divisor;
	cm_pkg::level_t div_quotient;
	logic div_done;
	// Strobes and judge feedback
	logic brew_check;
	logic supply_done;
	logic brew_ok;
	cm_pkg::flavor_t flavor;
	logic [cm_pkg::NUM_TANKS-1:0] short;

	tank_if tank_bus [cm_pkg::NUM_TANKS] ();

	order_ctrl u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.select_i(select_i),
		.supply(supply),
		.flavor_btn(flavor_btn),
		.required_size(required_size),
		.tanks(tank_bus),
		.div_start(div_start),
		.div_dividend(div_dividend),
		.div_divisor(div_divisor),
		.div_quotient(div_quotient),
		.div_done(div_done),
		.brew_check(brew_check),
		.supply_done(supply_done),
		.flavor(flavor)
	);

	cup_divider u_div (
		.clk(clk),
		.rst_n(rst_n),
		.start(div_start),
		.dividend(div_dividend),
		.divisor(div_divisor),
		.quotient(div_quotient),
		.done(div_done)
	);

	// ####################
	// Tanks in selector order
	for (genvar k = 0; k < cm_pkg::NUM_TANKS; k++)
	begin : g_tank
		ingredient_tank u_tank (
			.clk(clk),
			.rst_n(rst_n),
			.cmd(tank_bus[k]),
			.brew_ok(brew_ok),
			.short(short[k]),
			.level(level[k]),
			.led(led[k])
		);
	end

	brew_judge u_judge (
		.clk(clk),
		.rst_n(rst_n),
		.short(short),
		.brew_check(brew_check),
		.supply_done(supply_done),
		.flavor(flavor),
		.brew_ok(brew_ok),
		.out_valid(out_valid),
		.flavor_out(flavor_out)
	);
endmodule

/* tb/cm_model.svh */
// Reference model of the coffee maker tanks and the typed compare tasks
// Included inside the testbench module and shares its variables
`ifndef CM_MODEL_SVH
`define CM_MODEL_SVH

	// ####################
	// Model state
	int m_level [cm_pkg::NUM_TANKS];
	cm_pkg::led_t m_led [cm_pkg::NUM_TANKS];

	// Empty levels and red LEDs
	task automatic model_reset();
		for (int k = 0; k < cm_pkg::NUM_TANKS; k++)
		begin
			m_level[k] = 0;
			m_led[k] = cm_pkg::red;
		end
	endtask

	function automatic int model_cup(input cm_pkg::size_t sz);
		case (sz)
			cm_pkg::s: return int'(cm_pkg::CUP_S);
			cm_pkg::m: return int'(cm_pkg::CUP_M);
			cm_pkg::l: return int'(cm_pkg::CUP_L);
			cm_pkg::xl: return int'(cm_pkg::CUP_XL);
			default: return 0;
		endcase
	endfunction

	function automatic int model_ratio(input cm_pkg::flavor_t f, input int k);
		case (f)
			cm_pkg::latte: return int'(cm_pkg::LATTE_RATIO[k]);
			cm_pkg::cappuccino: return int'(cm_pkg::CAPPU_RATIO[k]);
			cm_pkg::mocha: return int'(cm_pkg::MOCHA_RATIO[k]);
			default: return 0;
		endcase
	endfunction

	// Refill wraps at the level width
	task automatic model_refill(input int k, input cm_pkg::level_t amt);
		m_level[k] = (m_level[k] + int'(amt)) % (1 << cm_pkg::LEVEL_W);
	endtask

	// Every LED follows its level at the end of a burst
	task automatic model_supply_done();
		for (int k = 0; k < cm_pkg::NUM_TANKS; k++)
			m_led[k] = (m_level[k] == 0) ? cm_pkg::red : cm_pkg::green;
	endtask

	// All shares or nothing
	task automatic model_order(input cm_pkg::flavor_t f, input cm_pkg::size_t sz,
		output cm_pkg::flavor_t exp_f);
		int draw [cm_pkg::NUM_TANKS];
		int sum;
		int portion;
		logic ok;
		sum = 0;
		for (int k = 0; k < cm_pkg::NUM_TANKS; k++)
			sum = sum + model_ratio(f, k);
		portion = model_cup(sz) / sum;
		ok = 1'b1;
		for (int k = 0; k < cm_pkg::NUM_TANKS; k++)
		begin
			draw[k] = portion * model_ratio(f, k);
			if (draw[k] > m_level[k])
				ok = 1'b0;
		end
		for (int k = 0; k < cm_pkg::NUM_TANKS; k++)
		begin
			if (ok)
			begin
				m_level[k] = m_level[k] - draw[k];
				m_led[k] = (m_level[k] == 0) ? cm_pkg::red : cm_pkg::green;
			end
			else
				m_led[k] = (draw[k] > m_level[k] || m_level[k] == 0) ? cm_pkg::red : cm_pkg::green;
		end
		exp_f = ok ? f : cm_pkg::no_coffee;
	endtask

	// ####################
	// Compare tasks
	task automatic check_flavor(input string name, input cm_pkg::flavor_t exp,
		input cm_pkg::flavor_t act);
		if (act !== exp)
		begin
			$display("Mismatch %s: expected %s actual %s", name, exp.name(), act.name());
			$display("TEST FAIL");
			$fatal(1, "Wrong flavor on the result");
		end
	endtask

	task automatic check_level(input string name, input cm_pkg::level_t exp,
		input cm_pkg::level_t act);
		if (act !== exp)
		begin
			$display("Mismatch %s: expected %0d actual %0d", name, exp, act);
			$display("TEST FAIL");
			$fatal(1, "Wrong tank level");
		end
	endtask

	task automatic check_led(input string name, input cm_pkg::led_t exp, input cm_pkg::led_t act);
		if (act !== exp)
		begin
			$display("Mismatch %s: expected %s actual %s", name, exp.name(), act.name());
			$display("TEST FAIL");
			$fatal(1, "Wrong tank LED");
		end
	endtask

`endif

/* tb/tb_coffee_maker.sv */
`timescale 1ns/1ns
// Self-checking testbench of the coffee maker
// Refills and orders from a fixed seed are checked against the model on every out_valid
module tb_coffee_maker;
	// Timeout budget in operations times cycles per operation
	localparam int NUM_OPS = 60;
	localparam int OP_CYCLES = 20;
	localparam int MAX_CYCLES = NUM_OPS * OP_CYCLES;
	localparam int MIX_OPS = 40;
	// Top-up keeps every tank above the largest single draw
	localparam int LOW_MARK = 300;
	localparam int FULL_MARK = 1000;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	cm_pkg::ingredient_t select_i = cm_pkg::none;
	cm_pkg::level_t supply = '0;
	cm_pkg::flavor_t flavor_btn = cm_pkg::no_coffee;
	cm_pkg::size_t required_size = cm_pkg::no_size;
	logic out_valid;
	cm_pkg::flavor_t flavor_out;
	cm_pkg::level_t level [cm_pkg::NUM_TANKS];
	cm_pkg::led_t led [cm_pkg::NUM_TANKS];

	int seed = 9;
	int cycle_count = 0;
	// Pending refill burst
	int burst_tank [$];
	cm_pkg::level_t burst_amt [$];

	`include "cm_model.svh"

	coffee_maker DUT (
		.clk(clk),
		.rst_n(rst_n),
		.select_i(select_i),
		.supply(supply),
		.flavor_btn(flavor_btn),
		.required_size(required_size),
		.out_valid(out_valid),
		.flavor_out(flavor_out),
		.level(level),
		.led(led)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("TEST FAIL");
			$fatal(1, "Timeout after %0d cycles, the tests did not finish", cycle_count);
		end
	end

	// Results settle on the out_valid edge and are sampled at the falling edge
	task automatic wait_result();
		@(negedge clk);
		while (!out_valid)
			@(negedge clk);
	endtask

	task automatic check_results(input string name, input cm_pkg::flavor_t exp_f);
		check_flavor(name, exp_f, flavor_out);
		for (int k = 0; k < cm_pkg::NUM_TANKS; k++)
		begin
			check_level($sformatf("%s tank %0d", name, k), cm_pkg::level_t'(m_level[k]), level[k]);
			check_led($sformatf("%s tank %0d", name, k), m_led[k], led[k]);
		end
	endtask

	// ####################
	// Stimulus
	task automatic run_refill(input string name);
		for (int i = 0; i < burst_tank.size(); i++)
		begin
			@(posedge clk);
			select_i <= cm_pkg::ingredient_t'(burst_tank[i] + 1);
			supply <= burst_amt[i];
			model_refill(burst_tank[i], burst_amt[i]);
		end
		// Idle select closes the burst
		@(posedge clk);
		select_i <= cm_pkg::none;
		supply <= '0;
		burst_tank.delete();
		burst_amt.delete();
		model_supply_done();
		wait_result();
		check_results(name, cm_pkg::no_coffee);
	endtask

	task automatic run_order(input string name, input cm_pkg::flavor_t f, input cm_pkg::size_t sz);
		cm_pkg::flavor_t exp_f;
		@(posedge clk);
		flavor_btn <= f;
		required_size <= sz;
		// Buttons released once the order is taken
		@(posedge clk);
		flavor_btn <= cm_pkg::no_coffee;
		required_size <= cm_pkg::no_size;
		model_order(f, sz, exp_f);
		wait_result();
		check_results(name, exp_f);
	endtask

	task automatic add_random_burst();
		int n;
		n = 1 + int'($unsigned($random(seed)) % 6);
		for (int i = 0; i < n; i++)
		begin
			burst_tank.push_back(int'($unsigned($random(seed)) % cm_pkg::NUM_TANKS));
			burst_amt.push_back(cm_pkg::level_t'($random(seed)));
		end
	endtask

	// Supply that wraps the tank to an exact level
	task automatic add_level_target(input int k, input int target);
		burst_tank.push_back(k);
		burst_amt.push_back(cm_pkg::level_t'(target - m_level[k]));
	endtask

	task automatic top_up(input string name);
		for (int k = 0; k < cm_pkg::NUM_TANKS; k++)
			if (m_level[k] < LOW_MARK)
				add_level_target(k, FULL_MARK);
		if (burst_tank.size() != 0)
			run_refill(name);
	endtask

	// ####################
	// Test sequence
	initial
	begin
		cm_pkg::flavor_t f;
		cm_pkg::size_t sz;
		model_reset();
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		// After reset
		@(negedge clk);
		if (out_valid !== 1'b0)
		begin
			$display("TEST FAIL");
			$fatal(1, "out_valid is not low after reset");
		end
		check_results("reset", cm_pkg::no_coffee);

		// Random refill bursts
		for (int i = 0; i < 4; i++)
		begin
			add_random_burst();
			run_refill($sformatf("refill %0d", i));
		end

		// Every preset at every size with the tanks kept full
		for (int fi = 1; fi <= 3; fi++)
			for (int si = 1; si <= 4; si++)
			begin
				f = cm_pkg::flavor_t'(fi);
				sz = cm_pkg::size_t'(si);
				top_up("top up");
				run_order($sformatf("brew %s %s", f.name(), sz.name()), f, sz);
			end

		// Espresso and chocolate too low
		add_level_target(0, 10);
		add_level_target(2, 50);
		run_refill("drain setup");
		run_order("short mocha", cm_pkg::mocha, cm_pkg::xl);
		run_order("short latte", cm_pkg::latte, cm_pkg::s);

		// Random mix
		for (int i = 0; i < MIX_OPS; i++)
		begin
			if ($random(seed) & 1)
			begin
				add_random_burst();
				run_refill($sformatf("mix %0d refill", i));
			end
			else
			begin
				f = cm_pkg::flavor_t'(1 + int'($unsigned($random(seed)) % 3));
				sz = cm_pkg::size_t'(1 + int'($unsigned($random(seed)) % 4));
				run_order($sformatf("mix %0d order", i), f, sz);
			end
		end

		$display("TEST PASS");
		$finish;
	end
endmodule

/* vlog.f */
+incdir+tb
verilog/cm_pkg.sv
verilog/tank_if.sv
verilog/order_ctrl.sv
verilog/cup_divider.sv
verilog/ingredient_tank.sv
verilog/brew_judge.sv
verilog/coffee_maker.sv
tb/tb_coffee_maker.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the coffee maker testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module tb_coffee_maker \
	-f vlog.f \
	--Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0
